/* common/stepper_pkg.sv */
package stepper_pkg;

  // One SPI word, header byte in the top 8 bits
  typedef logic [63:0] word_t;
  typedef logic [7:0] hdr_t;

  // Command codes
  localparam hdr_t CMD_MOVE      = 8'd1;  // Header + one payload word
  localparam hdr_t CMD_DIVISOR   = 8'd3;
  localparam hdr_t CMD_MICROSTEP = 8'd4;

  // CLK cycles per tick
  typedef logic [23:0] divisor_t;
  localparam divisor_t DEFAULT_DIVISOR = 24'd32;

  // Microstep mode, 4*2^m steps per electrical cycle
  typedef logic [2:0] ustep_t;
  localparam ustep_t USTEP_MAX = 3'd4;

  // Move length in ticks
  typedef logic [31:0] duration_t;

  // Signed velocity and acceleration terms
  typedef logic signed [31:0] rate_t;

  // Step phase accumulator
  typedef logic [31:0] accum_t;

  // Electrical position of the bridge, one cycle is 1024
  typedef logic [9:0] epos_t;

  // Decoder FSM
  typedef enum logic [1:0] {
    IDLE,
    WAIT_PAYLOAD,  // Move header seen, velocity/accel word next
    OFFER_MOVE     // Move pending, waiting for the step generator
  } dec_state_t;

endpackage

/* spi/spi_word_rx.sv */
module spi_word_rx #(
  parameter int WORD_BITS = 64
) (
  input  logic               CLK,
  input  logic               rst,
  input  logic               sck,
  input  logic               ssel,
  input  logic               mosi,
  output logic               miso,
  output logic               word_req,
  input  logic               word_ack,
  output stepper_pkg::word_t word_data,
  output logic               overrun
);
  import stepper_pkg::*;

  localparam int CNT_W = $clog2(WORD_BITS + 1);

  logic [1:0] sck_s;
  logic [1:0] ssel_s;
  logic [1:0] mosi_s;
  logic sck_d;
  logic ssel_d;
  logic [CNT_W-1:0] bit_cnt;
  word_t rx_shift;
  word_t tx_shift;
  word_t echo_word;  // Last complete word, sent back on the next transfer
  logic sck_rise;
  logic sck_fall;
  logic ssel_rise;
  logic ssel_fall;
  logic word_done;
  logic hs_idle;

  assign sck_rise  = sck_s[1] && !sck_d;
  assign sck_fall  = !sck_s[1] && sck_d;
  assign ssel_rise = ssel_s[1] && !ssel_d;
  assign ssel_fall = !ssel_s[1] && ssel_d;
  assign word_done = ssel_rise && (bit_cnt == CNT_W'(WORD_BITS));
  assign hs_idle   = !word_req && !word_ack;

  assign miso = tx_shift[$bits(word_t)-1];  // MSB first

  // Two-flop synchronizers into the CLK domain
  always_ff @(posedge CLK) begin
    if (rst) begin
      sck_s  <= 2'b00;
      ssel_s <= 2'b11;  // Deselected
      sck_d  <= 1'b0;
      ssel_d <= 1'b1;
    end else begin
      sck_s  <= {sck_s[0], sck};
      ssel_s <= {ssel_s[0], ssel};
      sck_d  <= sck_s[1];
      ssel_d <= ssel_s[1];
    end
    mosi_s <= {mosi_s[0], mosi};
  end

  // Bit count and handshake
  always_ff @(posedge CLK) begin
    if (rst) begin
      bit_cnt  <= '0;
      word_req <= 1'b0;
      overrun  <= 1'b0;
    end else begin
      if (ssel_fall)
        bit_cnt <= '0;
      else if (sck_rise && !ssel_s[1] && bit_cnt != CNT_W'(WORD_BITS))
        bit_cnt <= bit_cnt + 1'b1;

      if (word_req && word_ack)
        word_req <= 1'b0;
      else if (word_done && hs_idle)
        word_req <= 1'b1;

      if (word_done && !hs_idle)
        overrun <= 1'b1;  // Sticky, the word is lost
    end
  end

  // Shift registers
  always_ff @(posedge CLK) begin
    if (sck_rise && !ssel_s[1])
      rx_shift <= {rx_shift[$bits(word_t)-2:0], mosi_s[1]};

    if (ssel_fall)
      tx_shift <= echo_word;
    else if (sck_fall && !ssel_s[1])
      tx_shift <= {tx_shift[$bits(word_t)-2:0], 1'b0};

    if (word_done) begin
      echo_word <= rx_shift;
      if (hs_idle)
        word_data <= rx_shift;
    end
  end

  a_word_stable : assert property (@(posedge CLK) disable iff (rst)
    word_req |=> !word_req || $stable(word_data))
    else $error("word_data changed while word_req was high");

endmodule

/* design/command_decoder.sv */
module command_decoder (
  input  logic                   CLK,
  input  logic                   rst,
  input  logic                   word_req,
  output logic                   word_ack,
  input  stepper_pkg::word_t     word_data,
  output stepper_pkg::divisor_t  divisor,
  output stepper_pkg::ustep_t    ustep_mode,
  output logic                   move_req,
  input  logic                   move_ack,
  output logic                   move_dir,
  output stepper_pkg::duration_t move_duration,
  output stepper_pkg::rate_t     move_velocity,
  output stepper_pkg::rate_t     move_accel
);
  import stepper_pkg::*;

  dec_state_t state;
  hdr_t hdr;
  logic take;      // Word acknowledged and still presented
  logic can_ack;

  assign hdr  = word_data[63:56];
  assign take = word_req && word_ack;

  // Only one move fits in the pending slot
  assign can_ack = !(state == OFFER_MOVE && hdr == CMD_MOVE);

  always_ff @(posedge CLK) begin
    if (rst) begin
      word_ack <= 1'b0;
    end else if (word_ack && !word_req) begin
      word_ack <= 1'b0;
    end else if (word_req && !word_ack && can_ack) begin
      word_ack <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      state      <= IDLE;
      divisor    <= DEFAULT_DIVISOR;
      ustep_mode <= '0;
      move_req   <= 1'b0;
    end else begin
      // Settings words pass in any state except the payload slot
      if (take && state != WAIT_PAYLOAD) begin
        if (hdr == CMD_DIVISOR)
          divisor <= (word_data[23:0] == '0) ? divisor_t'(1) : word_data[23:0];
        if (hdr == CMD_MICROSTEP)
          ustep_mode <= (word_data[2:0] > USTEP_MAX) ? USTEP_MAX : word_data[2:0];
      end

      case (state)
        IDLE: begin
          if (take && hdr == CMD_MOVE)
            state <= WAIT_PAYLOAD;
        end
        WAIT_PAYLOAD: begin
          if (take) begin
            move_req <= !move_ack;  // Previous handshake normally long done
            state    <= OFFER_MOVE;
          end
        end
        OFFER_MOVE: begin
          if (move_req && move_ack) begin
            move_req <= 1'b0;
            state    <= IDLE;
          end else if (!move_req && !move_ack) begin
            move_req <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Move fields, held while move_req is high
  always_ff @(posedge CLK) begin
    if (take && state == IDLE && hdr == CMD_MOVE) begin
      move_dir      <= word_data[0];
      move_duration <= word_data[31:0];
    end
    if (take && state == WAIT_PAYLOAD) begin
      move_velocity <= word_data[63:32];
      move_accel    <= word_data[31:0];
    end
  end

  a_move_req_held : assert property (@(posedge CLK) disable iff (rst)
    $fell(move_req) |-> $past(move_ack))
    else $error("move_req dropped before move_ack");

endmodule

/* design/step_generator.sv */
module step_generator (
  input  logic                   CLK,
  input  logic                   rst,
  input  stepper_pkg::divisor_t  divisor,
  input  logic                   move_req,
  output logic                   move_ack,
  input  logic                   move_dir,
  input  stepper_pkg::duration_t move_duration,
  input  stepper_pkg::rate_t     move_velocity,
  input  stepper_pkg::rate_t     move_accel,
  output logic                   busy,
  output logic                   step,
  output logic                   dir
);
  import stepper_pkg::*;

  divisor_t div_cur;  // Divisor of the running tick
  divisor_t div_cnt;
  duration_t k;       // Ticks done so far
  duration_t k_next;
  duration_t dur_r;
  rate_t vel_r;
  rate_t accel_r;
  rate_t inc_term;
  accum_t acc;
  logic [33:0] sum_ext;
  logic tick;
  logic fin;          // Last tick done, busy drops next

  assign tick     = (div_cnt >= div_cur - 1'b1);
  assign k_next   = k + 1'b1;
  assign inc_term = vel_r + rate_t'(k_next) * accel_r;

  // Bits 33..32 nonzero on carry out or on a negative sum
  assign sum_ext = {2'b00, acc} + {{2{inc_term[31]}}, inc_term};

  always_ff @(posedge CLK) begin
    if (rst) begin
      move_ack <= 1'b0;
      busy     <= 1'b0;
      fin      <= 1'b0;
      step     <= 1'b0;
      acc      <= '0;
      div_cnt  <= '0;
      div_cur  <= DEFAULT_DIVISOR;
      k        <= '0;
    end else begin
      step <= 1'b0;

      if (move_ack && !move_req)
        move_ack <= 1'b0;

      if (!busy) begin
        if (move_req && !move_ack) begin
          move_ack <= 1'b1;
          busy     <= 1'b1;
          fin      <= (move_duration == '0);  // Empty move
          acc      <= '0;                     // Each move starts from a clear phase
          div_cnt  <= '0;
          div_cur  <= divisor;
          k        <= '0;
        end
      end else if (fin) begin
        busy <= 1'b0;
        fin  <= 1'b0;
      end else if (tick) begin
        div_cnt <= '0;
        div_cur <= divisor;  // New divisor applies from here
        k       <= k_next;
        acc     <= sum_ext[31:0];
        step    <= (sum_ext[33:32] != 2'b00);
        if (k_next == dur_r)
          fin <= 1'b1;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // Move latched at start, the decoder may load the next one meanwhile
  always_ff @(posedge CLK) begin
    if (!busy && move_req && !move_ack) begin
      dir     <= move_dir;
      dur_r   <= move_duration;
      vel_r   <= move_velocity;
      accel_r <= move_accel;
    end
  end

  // A tick every cycle can carry twice in a row
  a_step_pulse : assert property (@(posedge CLK) disable iff (rst)
    (step && div_cur != divisor_t'(1)) |=> !step)
    else $error("step high for two cycles");

endmodule

/* design/hbridge_driver.sv */
module hbridge_driver (
  input  logic                CLK,
  input  logic                rst,
  input  logic                step,
  input  logic                dir,
  input  stepper_pkg::ustep_t ustep_mode,
  output logic                phase_a1,
  output logic                phase_a2,
  output logic                phase_b1,
  output logic                phase_b2,
  output logic                pwm_a,
  output logic                pwm_b
);
  import stepper_pkg::*;

  epos_t position;
  epos_t step_size;
  logic [1:0] quadrant;
  logic [7:0] offset;    // Position inside the quadrant
  logic [7:0] pwm_cnt;

  // Full step is a quarter of the electrical cycle
  assign step_size = epos_t'(256) >> ustep_mode;
  assign quadrant  = position[9:8];
  assign offset    = position[7:0];

  always_ff @(posedge CLK) begin
    if (rst) begin
      position <= '0;
      pwm_cnt  <= '0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1;  // Free running
      if (step) begin
        if (dir)
          position <= position + step_size;
        else
          position <= position - step_size;
      end
    end
  end

  // Quadrant order A+B+, A-B+, A-B-, A+B-
  always_comb begin
    case (quadrant)
      2'd0: {phase_a1, phase_a2, phase_b1, phase_b2} = 4'b1010;
      2'd1: {phase_a1, phase_a2, phase_b1, phase_b2} = 4'b0110;
      2'd2: {phase_a1, phase_a2, phase_b1, phase_b2} = 4'b0101;
      default: {phase_a1, phase_a2, phase_b1, phase_b2} = 4'b1001;
    endcase
  end

  // Linear current ramp, A fades out while B fades in
  assign pwm_a = (pwm_cnt <= 8'd255 - offset);
  assign pwm_b = (pwm_cnt <= offset);

endmodule

/* design/stepper_top.sv */
module stepper_top #(
  parameter int WORD_BITS = 64
) (
  input  logic CLK,
  input  logic rst,
  input  logic sck,
  input  logic ssel,
  input  logic mosi,
  output logic miso,
  output logic phase_a1,
  output logic phase_a2,
  output logic phase_b1,
  output logic phase_b2,
  output logic pwm_a,
  output logic pwm_b,
  output logic busy,
  output logic step,
  output logic overrun
);
  import stepper_pkg::*;

  logic word_req;
  logic word_ack;
  word_t word_data;
  divisor_t divisor;
  ustep_t ustep_mode;
  logic move_req;
  logic move_ack;
  logic move_dir;
  duration_t move_duration;
  rate_t move_velocity;
  rate_t move_accel;
  logic dir;

  spi_word_rx #(
    .WORD_BITS(WORD_BITS)
  ) u_spi (
    .CLK(CLK), .rst(rst),
    .sck(sck), .ssel(ssel), .mosi(mosi), .miso(miso),
    .word_req(word_req), .word_ack(word_ack), .word_data(word_data),
    .overrun(overrun)
  );

  command_decoder u_dec (
    .CLK(CLK), .rst(rst),
    .word_req(word_req), .word_ack(word_ack), .word_data(word_data),
    .divisor(divisor), .ustep_mode(ustep_mode),
    .move_req(move_req), .move_ack(move_ack), .move_dir(move_dir),
    .move_duration(move_duration), .move_velocity(move_velocity),
    .move_accel(move_accel)
  );

  step_generator u_gen (
    .CLK(CLK), .rst(rst), .divisor(divisor),
    .move_req(move_req), .move_ack(move_ack), .move_dir(move_dir),
    .move_duration(move_duration), .move_velocity(move_velocity),
    .move_accel(move_accel),
    .busy(busy), .step(step), .dir(dir)
  );

  hbridge_driver u_drv (
    .CLK(CLK), .rst(rst), .step(step), .dir(dir), .ustep_mode(ustep_mode),
    .phase_a1(phase_a1), .phase_a2(phase_a2),
    .phase_b1(phase_b1), .phase_b2(phase_b2),
    .pwm_a(pwm_a), .pwm_b(pwm_b)
  );

endmodule

/* verif/spi_host_tasks.svh */
`ifndef SPI_HOST_TASKS_SVH
`define SPI_HOST_TASKS_SVH

// SPI mode 0 host, SCK at one sixteenth of CLK.
// All pin changes land 1 time unit after a rising CLK edge.

localparam int SCK_HALF = 8;  // CLK cycles per SCK half period

task automatic half_period();
  repeat (SCK_HALF) @(posedge CLK);
  #1;
endtask

// One 64-bit transfer, MSB first, MISO captured before each rising SCK
task automatic spi_transfer(input logic [63:0] tx, output logic [63:0] rx);
  int i;
  rx = '0;
  ssel = 1'b0;
  half_period();
  half_period();  // Slave loads its echo word meanwhile
  for (i = 63; i >= 0; i--) begin
    mosi = tx[i];
    half_period();
    rx[i] = miso;
    sck = 1'b1;
    half_period();
    sck = 1'b0;
  end
  half_period();
  ssel = 1'b1;
  half_period();  // Room for the word handshake
  half_period();
  mosi = 1'b0;
endtask

// Transfer where the echoed bits are not needed
task automatic spi_send(input logic [63:0] tx);
  logic [63:0] unused_rx;
  spi_transfer(tx, unused_rx);
endtask

// CLK cycles taken by one spi_transfer call
localparam int XFER_CYCLES = 2 * SCK_HALF + 64 * 2 * SCK_HALF + 3 * SCK_HALF;

`endif

/* verif/stepper_tb.sv */
module stepper_tb;
  import stepper_pkg::*;

  logic CLK;
  logic rst;
  logic sck;
  logic ssel;
  logic mosi;
  logic miso;
  logic phase_a1;
  logic phase_a2;
  logic phase_b1;
  logic phase_b2;
  logic pwm_a;
  logic pwm_b;
  logic busy;
  logic step;
  logic overrun;
  logic [3:0] phases;

  integer seed = 29600;
  int fail_cnt = 0;
  int check_cnt = 0;
  int test_cnt = 0;
  int test_fail_base = 0;
  int step_cnt;
  int busy_run;
  int busy_lens[$];      // Length of each finished busy pulse
  int cycles = 0;

  // Reference model state
  logic [9:0] model_pos;   // Follows the DUT step pulses
  logic [9:0] calc_pos;    // Predicted from the model step counts
  logic model_dir = 1'b1;
  logic [2:0] model_mode = 3'd0;

  // Value check strobe
  logic chk_en = 1'b0;
  string chk_name = "";
  logic [63:0] chk_exp = '0;
  logic [63:0] chk_act = '0;

  `include "spi_host_tasks.svh"

  // 26 SPI words and the tick cycles of every move in the tests
  localparam int N_WORDS = 26;
  localparam int MOVE_CYCLES = 21 * 32 + 11 * 5 + 10 * 1 + 21 * 32 + 34 * 32
                             + 151 * 32 + 31 * 32 + 17 * 32;
  localparam int LIMIT = 2 * (N_WORDS * XFER_CYCLES + MOVE_CYCLES + 4);

  assign phases = {phase_a1, phase_a2, phase_b1, phase_b2};

  stepper_top #(
    .WORD_BITS(64)
  ) dut0 (
    .CLK(CLK), .rst(rst), .sck(sck), .ssel(ssel), .mosi(mosi), .miso(miso),
    .phase_a1(phase_a1), .phase_a2(phase_a2),
    .phase_b1(phase_b1), .phase_b2(phase_b2),
    .pwm_a(pwm_a), .pwm_b(pwm_b), .busy(busy), .step(step), .overrun(overrun)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // Quadrant order A+B+, A-B+, A-B-, A+B-
  function automatic logic [3:0] phase_pattern(input logic [1:0] q);
    case (q)
      2'd0: return 4'b1010;
      2'd1: return 4'b0110;
      2'd2: return 4'b0101;
      default: return 4'b1001;
    endcase
  endfunction

  // Steps of one move from the accumulator rules, phase starts at 0
  function automatic int model_steps(input logic [31:0] dur, input int vel, input int acc);
    longint phase;
    longint sum;
    longint k;
    int inc;
    int n;
    phase = 0;
    n = 0;
    for (k = 1; k <= longint'(dur); k++) begin
      inc = vel + int'(k) * acc;
      sum = phase + longint'(inc);
      if (sum < 0 || sum >= 64'sh1_0000_0000)
        n++;  // Carry or borrow
      phase = sum & 64'h0000_0000_FFFF_FFFF;
    end
    return n;
  endfunction

  always @(posedge CLK) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
      $display("Something failed");
      $finish;
    end
  end

  always @(posedge CLK) begin
    if (rst) begin
      step_cnt = 0;
      model_pos = '0;
      busy_run = 0;
    end else begin
      if (step) begin
        step_cnt++;
        if (model_dir)
          model_pos = model_pos + (10'd256 >> model_mode);
        else
          model_pos = model_pos - (10'd256 >> model_mode);
      end
      if (busy)
        busy_run++;
      else if (busy_run != 0) begin
        busy_lens.push_back(busy_run);
        busy_run = 0;
      end
    end
  end

  a_value : assert property (@(posedge CLK) chk_en |-> chk_act == chk_exp)
    else begin
      $display("[FAIL] %0t %s expected %0h actual %0h", $time, chk_name, chk_exp, chk_act);
      fail_cnt++;
    end

  a_phase : assert property (@(posedge CLK) disable iff (rst)
    phases == phase_pattern(model_pos[9:8]))
    else begin
      $display("[FAIL] %0t phases expected %b actual %b", $time,
               phase_pattern($sampled(model_pos[9:8])), $sampled(phases));
      fail_cnt++;
    end

  a_overrun : assert property (@(posedge CLK) disable iff (rst) !$rose(overrun))
    else begin
      $display("[FAIL] %0t overrun expected 0 actual 1", $time);
      fail_cnt++;
    end

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    chk_name = name;
    chk_exp = exp;
    chk_act = act;
    chk_en = 1'b1;
    check_cnt++;
    @(posedge CLK);
    #1;
    chk_en = 1'b0;
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    $display("test %0d %s: %0d failures", test_cnt, name, fail_cnt - test_fail_base);
    test_fail_base = fail_cnt;
  endtask

  // Header then payload, dir comes from duration bit 0
  task automatic send_move(input logic [31:0] dur, input int vel, input int acc,
                           inout int exp_steps);
    int n;
    logic [9:0] size;
    n = model_steps(dur, vel, acc);
    size = 10'd256 >> model_mode;
    model_dir = dur[0];
    spi_send({CMD_MOVE, 24'd0, dur});
    spi_send({vel, acc});
    exp_steps += n;
    if (dur[0])
      calc_pos = calc_pos + 10'(n * size);
    else
      calc_pos = calc_pos - 10'(n * size);
  endtask

  task automatic finish_move(input int exp_len);
    while (busy_lens.size() == 0) begin
      @(posedge CLK);
      #1;
    end
    check_value("busy_length", exp_len, busy_lens.pop_front());
  endtask

  task automatic set_divisor(input logic [23:0] d);
    spi_send({CMD_DIVISOR, 32'd0, d});
  endtask

  task automatic set_mode(input logic [2:0] m);
    spi_send({CMD_MICROSTEP, 53'd0, m});
    model_mode = (m > 3'd4) ? 3'd4 : m;
  endtask

  initial begin
    logic [63:0] words[5];
    logic [63:0] rx;
    int exp_steps;
    int s0;
    int i;
    rst = 1'b1;
    sck = 1'b0;
    ssel = 1'b1;
    mosi = 1'b0;
    calc_pos = '0;

    repeat (2) @(posedge CLK);
    #1;
    check_value("reset_outputs", {busy, step, overrun, phases, pwm_a, pwm_b},
                {3'b000, 4'b1010, 2'b11});
    @(posedge CLK);
    #1;
    rst = 1'b0;
    end_test("reset");

    for (i = 0; i < 5; i++) begin
      words[i] = {8'hA5, 24'($random(seed)), 32'($random(seed))};  // Unknown header
      spi_transfer(words[i], rx);
      if (i > 0)
        check_value("miso_echo", words[i-1], rx);
    end
    end_test("echo");

    exp_steps = 0;
    s0 = step_cnt;
    send_move(21, $random(seed), 0, exp_steps);
    finish_move(21 * 32 + 1);
    check_value("step_count", exp_steps, step_cnt - s0);
    end_test("constant_velocity");

    exp_steps = 0;
    s0 = step_cnt;
    set_divisor(24'd5);
    send_move(11, $random(seed), 0, exp_steps);
    finish_move(11 * 5 + 1);
    set_divisor(24'd0);  // Acts as 1
    send_move(10, $random(seed), 0, exp_steps);
    finish_move(10 * 1 + 1);
    check_value("step_count", exp_steps, step_cnt - s0);
    end_test("divisor");

    exp_steps = 0;
    s0 = step_cnt;
    set_divisor(24'd32);
    set_mode(3'd2);
    send_move(21, 32'sh6000_0000, 0, exp_steps);
    finish_move(21 * 32 + 1);
    check_value("phases", phase_pattern(calc_pos[9:8]), phases);
    set_mode(3'd7);
    // Reverse move long enough to leave the quadrant only with the clamped step size
    send_move(34, -32'sh7000_0000, 0, exp_steps);
    finish_move(34 * 32 + 1);
    check_value("phases", phase_pattern(calc_pos[9:8]), phases);
    check_value("step_count", exp_steps, step_cnt - s0);
    end_test("microstep");

    exp_steps = 0;
    s0 = step_cnt;
    send_move(151, $random(seed), $random(seed) % 1000, exp_steps);
    send_move(31, $random(seed), $random(seed) % 1000, exp_steps);
    // Third header waits for the pending slot, payload follows later
    exp_steps += model_steps(17, 32'sh2345_6789, 77);
    model_dir = 1'b1;
    spi_send({CMD_MOVE, 24'd0, 32'd17});
    finish_move(151 * 32 + 1);
    spi_send({32'sh2345_6789, 32'sd77});
    finish_move(31 * 32 + 1);
    finish_move(17 * 32 + 1);
    check_value("step_count", exp_steps, step_cnt - s0);
    check_value("overrun", 0, overrun);
    end_test("back_pressure");

    $display("%0d tests, %0d checks, %0d failures", test_cnt, check_cnt, fail_cnt);
    if (fail_cnt == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

/* files.f */
+incdir+verif
common/stepper_pkg.sv
spi/spi_word_rx.sv
design/command_decoder.sv
design/step_generator.sv
design/hbridge_driver.sv
design/stepper_top.sv
verif/stepper_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= stepper_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
